// ==== src/SboxTable.svh ====
//**********************************************************
// forward AES S-box, included inside AesPkg after byte_t
//**********************************************************
`ifndef SBOX_TABLE_SVH
`define SBOX_TABLE_SVH

    // one row of sixteen bytes per line, entry 0 in the leftmost position
    localparam byte_t [0:255] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

`endif

// ==== src/AesPkg.sv ====
//**********************************************************
// AES-128 types, constants and byte transforms for the core
// block byte 0 is the most significant byte, as in FIPS-197
//**********************************************************
`default_nettype none

package AesPkg;

    localparam int NUM_ROUNDS = 10;
    localparam int KEY_BITS = 128;
    localparam int BLOCK_BYTES = KEY_BITS / 8;

    // wide enough to count every level of the key delay chain
    localparam int LEVEL_BITS = $clog2(NUM_ROUNDS + 1);

    typedef logic [7:0] byte_t;
    typedef byte_t [0:3] word_t;
    typedef byte_t [0:BLOCK_BYTES-1] block_t;
    typedef block_t [0:NUM_ROUNDS] roundKeys_t;

    // one block travelling down the pipeline
    typedef struct packed {
        logic   valid;
        block_t state;
    } pipeStage_t;

    // round constants, entry r is folded into round key r
    localparam byte_t [1:NUM_ROUNDS] RCON = {
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

`include "SboxTable.svh"

    function automatic byte_t subByte(input byte_t value);
        return SBOX[value];
    endfunction

    function automatic word_t subWord(input word_t column);
        word_t result;
        for (int i = 0; i < 4; i++)
        begin
            result[i] = subByte(column[i]);
        end
        return result;
    endfunction

    // bytes are stored column by column, so byte 4*c+r is row r of column c
    function automatic block_t shiftRows(input block_t state);
        block_t result;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                result[4*c + r] = state[4*((c + r) % 4) + r];
            end
        end
        return result;
    endfunction

    // multiply by x in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(input byte_t value);
        return {value[6:0], 1'b0} ^ (value[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic block_t mixColumns(input block_t state);
        block_t result;
        word_t  col;
        for (int c = 0; c < 4; c++)
        begin
            col = state[4*c +: 4];
            // each row is {02 03 01 01} rotated, with 03*a written as xtime(a) ^ a
            result[4*c]     = xtime(col[0]) ^ xtime(col[1]) ^ col[1] ^ col[2] ^ col[3];
            result[4*c + 1] = col[0] ^ xtime(col[1]) ^ xtime(col[2]) ^ col[2] ^ col[3];
            result[4*c + 2] = col[0] ^ col[1] ^ xtime(col[2]) ^ xtime(col[3]) ^ col[3];
            result[4*c + 3] = xtime(col[0]) ^ col[0] ^ col[1] ^ col[2] ^ xtime(col[3]);
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== src/KeyExpand.sv ====
//**********************************************************
// AES-128 key schedule, delayed one level per round stage
// key levels have no reset and hold unknowns until filled
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module KeyExpand
(
    input  logic               clock,
    input  logic               reset,
    input  AesPkg::block_t     key,
    output AesPkg::roundKeys_t roundKeys
);

    import AesPkg::*;

    // full schedule of the key presented this cycle
    roundKeys_t schedule;

    // level i holds the schedule of the key taken i edges earlier
    roundKeys_t chain [1:NUM_ROUNDS];

    // edges seen since reset, saturating once every level is loaded
    logic [LEVEL_BITS-1:0] fillCount;

    function automatic word_t rotWord(input word_t column);
        return {column[1:3], column[0]};
    endfunction

    // derives the next round key from the previous one
    function automatic block_t expandBlock(input block_t prevKey, input byte_t rcon);
        word_t  feed;
        block_t nextKey;
        feed = subWord(rotWord(prevKey[12:15]));
        // the round constant only touches the top byte of the column
        feed[0] = feed[0] ^ rcon;
        nextKey[0:3] = prevKey[0:3] ^ feed;
        for (int c = 1; c < 4; c++)
        begin
            nextKey[4*c +: 4] = nextKey[4*(c-1) +: 4] ^ prevKey[4*c +: 4];
        end
        return nextKey;
    endfunction

    always_comb
    begin
        schedule[0] = key;
        for (int r = 1; r <= NUM_ROUNDS; r++)
        begin
            schedule[r] = expandBlock(schedule[r-1], RCON[r]);
        end
    end

    // the whole schedule moves with its block so every stage sees its own key
    always_ff @(posedge clock)
    begin
        chain[1] <= schedule;
        for (int i = 2; i <= NUM_ROUNDS; i++)
        begin
            chain[i] <= chain[i-1];
        end
    end

    // round key 0 is used by the entry stage in the same cycle the key arrives
    always_comb
    begin
        roundKeys[0] = schedule[0];
        for (int i = 1; i <= NUM_ROUNDS; i++)
        begin
            roundKeys[i] = chain[i][i];
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            fillCount <= '0;
        else if (fillCount != LEVEL_BITS'(NUM_ROUNDS))
            fillCount <= fillCount + 1'b1;
    end

    // after the chain has been loaded from reset, no stage reads an unknown key
    keysKnown: assert property (
        @(posedge clock) disable iff (reset)
        (fillCount == LEVEL_BITS'(NUM_ROUNDS)) |-> !$isunknown(roundKeys)
    );

endmodule

`default_nettype wire

// ==== src/CipherEntry.sv ====
//**********************************************************
// initial AddRoundKey, one cycle of latency
// only the valid bit is cleared by reset
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module CipherEntry
(
    input  logic               clock,
    input  logic               reset,
    input  logic               inValid,
    input  AesPkg::block_t     inBlock,
    input  AesPkg::block_t     roundKey,
    output AesPkg::pipeStage_t stage
);

    import AesPkg::*;

    block_t whitened;

    // round key 0 is the cipher key itself
    always_comb
    begin
        whitened = inBlock ^ roundKey;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            stage.valid <= 1'b0;
        else
            stage.valid <= inValid;
        // the state is loaded every cycle, idle cycles just carry junk
        stage.state <= whitened;
    end

    // the strobe seen by the whole pipeline stays defined once out of reset
    validKnown: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(stage.valid)
    );

endmodule

`default_nettype wire

// ==== src/CipherRound.sv ====
//**********************************************************
// one full AES round with MixColumns, registered output
// roundKey must be the key that belongs to prevStage's block
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module CipherRound
(
    input  logic               clock,
    input  logic               reset,
    input  AesPkg::pipeStage_t prevStage,
    input  AesPkg::block_t     roundKey,
    output AesPkg::pipeStage_t stage
);

    import AesPkg::*;

    block_t subbed;
    block_t shifted;
    block_t nextState;

    // SubBytes works on every byte independently
    always_comb
    begin
        for (int i = 0; i < BLOCK_BYTES; i++)
        begin
            subbed[i] = subByte(prevStage.state[i]);
        end
    end

    always_comb
    begin
        shifted = shiftRows(subbed);
        nextState = mixColumns(shifted) ^ roundKey;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            stage.valid <= 1'b0;
        else
            stage.valid <= prevStage.valid;
        stage.state <= nextState;
    end

    // a block marked valid must have been built from known data and a known key
    stateKnown: assert property (
        @(posedge clock) disable iff (reset)
        stage.valid |-> !$isunknown(stage.state)
    );

endmodule

`default_nettype wire

// ==== src/CipherFinal.sv ====
//**********************************************************
// last AES round without MixColumns, drives the core outputs
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module CipherFinal
(
    input  logic               clock,
    input  logic               reset,
    input  AesPkg::pipeStage_t prevStage,
    input  AesPkg::block_t     roundKey,
    output logic               outValid,
    output AesPkg::block_t     outBlock
);

    import AesPkg::*;

    block_t subbed;
    block_t cipherText;

    always_comb
    begin
        for (int i = 0; i < BLOCK_BYTES; i++)
        begin
            subbed[i] = subByte(prevStage.state[i]);
        end
    end

    // the final round skips MixColumns
    always_comb
    begin
        cipherText = shiftRows(subbed) ^ roundKey;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            outValid <= 1'b0;
        else
            outValid <= prevStage.valid;
        outBlock <= cipherText;
    end

endmodule

`default_nettype wire

// ==== src/AesEncryptPipe.sv ====
//**********************************************************
// pipelined AES-128 encryption, one block per cycle
// ciphertext 11 cycles after inValid, no back-pressure
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module AesEncryptPipe
(
    input  logic           clock,
    input  logic           reset,
    input  logic           inValid,
    input  AesPkg::block_t inKey,
    input  AesPkg::block_t inBlock,
    output logic           outValid,
    output AesPkg::block_t outBlock
);

    import AesPkg::*;

    // round keys, element i aligned with the block in stage i
    roundKeys_t roundKeys;

    // stage[r] holds the block after round r
    pipeStage_t stage [0:NUM_ROUNDS-1];

    KeyExpand u_KeyExpand
    (
        .clock     (clock),
        .reset     (reset),
        .key       (inKey),
        .roundKeys (roundKeys)
    );

    CipherEntry u_CipherEntry
    (
        .clock    (clock),
        .reset    (reset),
        .inValid  (inValid),
        .inBlock  (inBlock),
        .roundKey (roundKeys[0]),
        .stage    (stage[0])
    );

    // rounds 1 to 9 are identical, round 10 is the final stage
    for (genvar r = 1; r < NUM_ROUNDS; r++)
    begin : gRound
        CipherRound u_CipherRound
        (
            .clock     (clock),
            .reset     (reset),
            .prevStage (stage[r-1]),
            .roundKey  (roundKeys[r]),
            .stage     (stage[r])
        );
    end

    CipherFinal u_CipherFinal
    (
        .clock     (clock),
        .reset     (reset),
        .prevStage (stage[NUM_ROUNDS-1]),
        .roundKey  (roundKeys[NUM_ROUNDS]),
        .outValid  (outValid),
        .outBlock  (outBlock)
    );

endmodule

`default_nettype wire

// ==== sim/ClockGen.sv ====
//**********************************************************
// free running testbench clock, 8 ns period, starts low
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module ClockGen
(
    output logic clock
);

    localparam int HALF_PERIOD_NS = 4;

    initial
    begin
        clock = 1'b0;
        forever #(HALF_PERIOD_NS) clock = ~clock;
    end

endmodule

`default_nettype wire

// ==== sim/AesEncryptPipeTb.sv ====
//**********************************************************
// AES-128 pipeline testbench, inputs and checks on the falling edge
// expects ciphertext exactly 11 cycles after the input cycle
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module AesEncryptPipeTb;

    import AesPkg::*;

    localparam int LATENCY = 11;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_VECTORS = 4;
    localparam int RANDOM_COUNT = 16;
    localparam int FLUSH_COUNT = 5;
    localparam int APPLIED = 2 * NUM_VECTORS + RANDOM_COUNT + FLUSH_COUNT + 1;
    // every entry costs at most its latency plus the widest random gap
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + APPLIED * (LATENCY + 4) + 40;

    typedef struct packed {
        block_t key;
        block_t plain;
        block_t cipher;
    } vector_t;

    typedef struct packed {
        int index;
        int dueCycle;
    } pending_t;

    logic        clock;
    logic        reset;
    logic        inValid;
    block_t      inKey;
    block_t      inBlock;
    logic        outValid;
    block_t      outBlock;

    vector_t     vectors [NUM_VECTORS];
    string       vectorNames [NUM_VECTORS];
    pending_t    scoreboard [$];
    logic [31:0] lfsrState;
    int          cycleCount;
    int          errorCount;
    int          testsRun;
    int          testsFailed;

    ClockGen u_ClockGen
    (
        .clock (clock)
    );

    AesEncryptPipe u_AesEncryptPipe
    (
        .clock    (clock),
        .reset    (reset),
        .inValid  (inValid),
        .inKey    (inKey),
        .inBlock  (inBlock),
        .outValid (outValid),
        .outBlock (outBlock)
    );

    task automatic setVector(input int idx, input string name, input block_t key,
                             input block_t plain, input block_t cipher);
        vectors[idx] = {key, plain, cipher};
        vectorNames[idx] = name;
    endtask

    // known answers from FIPS-197 and SP 800-38A
    task automatic loadVectors();
        setVector(0, "fips197 appendix b", 128'h2b7e151628aed2a6abf7158809cf4f3c,
                  128'h3243f6a8885a308d313198a2e0370734, 128'h3925841d02dc09fbdc118597196a0b32);
        setVector(1, "fips197 appendix c1", 128'h000102030405060708090a0b0c0d0e0f,
                  128'h00112233445566778899aabbccddeeff, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        setVector(2, "all zero", 128'h0,
                  128'h0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
        setVector(3, "sp800-38a ecb block 1", 128'h2b7e151628aed2a6abf7158809cf4f3c,
                  128'h6bc1bee22e409f96e93d7e117393172a, 128'h3ad77bb40d7a3660a89ecaf32466ef97);
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1, shifting right
    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h8020_0003;
        return state >> 1;
    endfunction

    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = stepLfsr(lfsrState);
        end
    endtask

    // outValid must be high exactly in the cycle a block is due and low otherwise
    task automatic checkOutputs();
        pending_t head;
        if (scoreboard.size() > 0 && scoreboard[0].dueCycle == cycleCount)
        begin
            head = scoreboard.pop_front();
            if (outValid !== 1'b1)
            begin
                $display("outValid is %b in cycle %0d, where %s was due",
                         outValid, cycleCount, vectorNames[head.index]);
                errorCount++;
            end
            else if (outBlock !== vectors[head.index].cipher)
            begin
                $display("mismatch %s: expected %h, actual %h",
                         vectorNames[head.index], vectors[head.index].cipher, outBlock);
                errorCount++;
            end
        end
        else if (outValid !== 1'b0)
        begin
            $display("outValid is %b in cycle %0d with no block due", outValid, cycleCount);
            errorCount++;
        end
    endtask

    // one clock cycle: check what the last rising edge produced, then drive the next input
    task automatic applyCycle(input logic valid, input int index, input logic resetValue);
        pending_t entry;
        @(negedge clock);
        cycleCount++;
        checkOutputs();
        reset = resetValue;
        inValid = valid;
        inKey = vectors[index].key;
        inBlock = vectors[index].plain;
        if (resetValue)
            scoreboard.delete();
        else if (valid)
        begin
            entry.index = index;
            entry.dueCycle = cycleCount + LATENCY;
            scoreboard.push_back(entry);
        end
    endtask

    task automatic drain();
        while (scoreboard.size() > 0)
            applyCycle(1'b0, 0, 1'b0);
        applyCycle(1'b0, 0, 1'b0);
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount == errorsBefore)
            $display("test %s: ok", name);
        else
        begin
            testsFailed++;
            $display("test %s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    initial
    begin
        int mark;
        int gap;
        reset = 1'b1;
        inValid = 1'b0;
        inKey = '0;
        inBlock = '0;
        cycleCount = 0;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        lfsrState = 32'h4410_cb0b;
        loadVectors();

        // reset is already high for the edge at 4 ns
        mark = errorCount;
        repeat (RESET_CYCLES - 1) applyCycle(1'b0, 0, 1'b1);
        finishTest("reset holds outValid low", mark);

        for (int v = 0; v < NUM_VECTORS; v++)
        begin
            mark = errorCount;
            applyCycle(1'b1, v, 1'b0);
            drain();
            finishTest(vectorNames[v], mark);
        end

        // a different key on every cycle shows the key chain stays with its block
        mark = errorCount;
        for (int v = 0; v < NUM_VECTORS; v++)
            applyCycle(1'b1, v, 1'b0);
        drain();
        finishTest("back to back keys", mark);

        mark = errorCount;
        for (int n = 0; n < RANDOM_COUNT; n++)
        begin
            drawBits(2, gap);
            repeat (gap) applyCycle(1'b0, 0, 1'b0);
            applyCycle(1'b1, n % NUM_VECTORS, 1'b0);
        end
        drain();
        finishTest("random gaps", mark);

        // blocks in flight at reset must never show up
        mark = errorCount;
        for (int n = 0; n < FLUSH_COUNT; n++)
            applyCycle(1'b1, n % NUM_VECTORS, 1'b0);
        repeat (3) applyCycle(1'b0, 0, 1'b1);
        applyCycle(1'b1, 1, 1'b0);
        drain();
        finishTest("reset in flight", mark);

        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles before all tests finished", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== aesEncryptPipe.f ====
+incdir+src
src/AesPkg.sv
src/KeyExpand.sv
src/CipherEntry.sv
src/CipherRound.sv
src/CipherFinal.sv
src/AesEncryptPipe.sv
sim/ClockGen.sv
sim/AesEncryptPipeTb.sv
